/* design/or1k_decode_pkg.sv */
// ########################################
// OpenRISC decode package
// Instruction fields, opcodes, ALU codes, feature
// selection and the fetch and decode records
// ########################################

`default_nettype none

package or1k_decode_pkg;

   // Widths
   localparam int insn_width    = 32;
   localparam int operand_width = 32;
   localparam int rf_addr_width = 5;
   localparam int opcode_width  = 6;
   localparam int alu_opc_width = 4;

   // Instruction field positions
   localparam int opcode_msb  = 31;
   localparam int opcode_lsb  = 26;
   localparam int rd_msb      = 25;
   localparam int rd_lsb      = 21;
   localparam int ra_msb      = 20;
   localparam int ra_lsb      = 16;
   localparam int rb_msb      = 15;
   localparam int rb_lsb      = 11;
   localparam int imm16_msb   = 15;
   localparam int imm16_lsb   = 0;
   localparam int alu_opc_msb = 3;
   localparam int alu_opc_lsb = 0;
   localparam int alu_sec_msb = 9;
   localparam int alu_sec_lsb = 6;
   localparam int comp_msb    = 24;
   localparam int comp_lsb    = 21;
   localparam int sys_msb     = 25;
   localparam int sys_lsb     = 21;

   // Major opcodes
   localparam logic [5:0] opc_j           = 6'h00;
   localparam logic [5:0] opc_jal         = 6'h01;
   localparam logic [5:0] opc_bnf         = 6'h03;
   localparam logic [5:0] opc_bf          = 6'h04;
   localparam logic [5:0] opc_nop         = 6'h05;
   localparam logic [5:0] opc_movhi       = 6'h06;
   localparam logic [5:0] opc_systrapsync = 6'h08;
   localparam logic [5:0] opc_rfe         = 6'h09;
   localparam logic [5:0] opc_jr          = 6'h11;
   localparam logic [5:0] opc_jalr        = 6'h12;
   localparam logic [5:0] opc_lwz         = 6'h21;
   localparam logic [5:0] opc_lws         = 6'h22;
   localparam logic [5:0] opc_lbz         = 6'h23;
   localparam logic [5:0] opc_lbs         = 6'h24;
   localparam logic [5:0] opc_lhz         = 6'h25;
   localparam logic [5:0] opc_lhs         = 6'h26;
   localparam logic [5:0] opc_addi        = 6'h27;
   localparam logic [5:0] opc_addic       = 6'h28;
   localparam logic [5:0] opc_andi        = 6'h29;
   localparam logic [5:0] opc_ori         = 6'h2a;
   localparam logic [5:0] opc_xori        = 6'h2b;
   localparam logic [5:0] opc_muli        = 6'h2c;
   localparam logic [5:0] opc_mfspr       = 6'h2d;
   localparam logic [5:0] opc_shrti       = 6'h2e;
   localparam logic [5:0] opc_sfimm       = 6'h2f;
   localparam logic [5:0] opc_mtspr       = 6'h30;
   localparam logic [5:0] opc_sw          = 6'h35;
   localparam logic [5:0] opc_sb          = 6'h36;
   localparam logic [5:0] opc_sh          = 6'h37;
   localparam logic [5:0] opc_alu         = 6'h38;
   localparam logic [5:0] opc_sf          = 6'h39;

   // ALU opcodes, low nibble of l.alu
   localparam logic [3:0] alu_add  = 4'h0;
   localparam logic [3:0] alu_addc = 4'h1;
   localparam logic [3:0] alu_sub  = 4'h2;
   localparam logic [3:0] alu_and  = 4'h3;
   localparam logic [3:0] alu_or   = 4'h4;
   localparam logic [3:0] alu_xor  = 4'h5;
   localparam logic [3:0] alu_mul  = 4'h6;
   localparam logic [3:0] alu_shrt = 4'h8;
   localparam logic [3:0] alu_div  = 4'h9;
   localparam logic [3:0] alu_divu = 4'ha;
   localparam logic [3:0] alu_mulu = 4'hb;
   localparam logic [3:0] alu_ext  = 4'hc;
   localparam logic [3:0] alu_cmov = 4'he;
   localparam logic [3:0] alu_ffl1 = 4'hf;

   // Shift and rotate secondaries
   localparam logic [3:0] shrt_sll = 4'h0;
   localparam logic [3:0] shrt_srl = 4'h1;
   localparam logic [3:0] shrt_sra = 4'h2;
   localparam logic [3:0] shrt_ror = 4'h3;

   localparam logic [4:0] sys_syscall = 5'h00;
   localparam logic [4:0] sys_trap    = 5'h08;
   localparam logic [4:0] link_reg    = 5'd9;

   // Optional instruction support
   localparam bit feat_syscall = 1'b1;
   localparam bit feat_trap    = 1'b1;
   localparam bit feat_sra     = 1'b1;
   localparam bit feat_mul     = 1'b1;
   localparam bit feat_ror     = 1'b0;
   localparam bit feat_div     = 1'b0;
   localparam bit feat_addc    = 1'b0;
   localparam bit feat_ffl1    = 1'b0;
   localparam bit feat_cmov    = 1'b0;
   localparam bit feat_ext     = 1'b0;

   typedef struct packed {
      logic [operand_width-1:0] pc;
      logic [insn_width-1:0]    insn;
   } fetch_t;

   typedef struct packed {
      logic [operand_width-1:0] pc;
      logic [opcode_width-1:0]  opc;
      logic [alu_opc_width-1:0] alu_opc;
      logic [alu_opc_width-1:0] alu_opc_sec;
      logic [operand_width-1:0] imm;
      logic                     imm_sel;
      logic [rf_addr_width-1:0] rfd;
      logic [rf_addr_width-1:0] rfa;
      logic [rf_addr_width-1:0] rfb;
      logic                     rf_wb;
      logic                     op_alu;
      logic                     op_load;
      logic                     op_store;
      logic [1:0]               lsu_len;
      logic                     lsu_zext;
      logic                     op_mfspr;
      logic                     op_mtspr;
      logic                     op_setflag;
      logic                     op_rfe;
      logic                     op_jbr;
      logic                     op_jr;
      logic                     op_jal;
      logic                     op_branch;
      logic                     adder_sub;
      logic                     adder_carry;
      logic                     exc_illegal;
      logic                     exc_syscall;
      logic                     exc_trap;
   } decode_t;

endpackage

`default_nettype wire

/* design/pipe_stage_reg.sv */
// ########################################
// Generic pipeline stage register
// Valid bit with stall and flush, any payload type
// ########################################

`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk,
   input  logic     rst_i,
   input  logic     stall_i,
   input  logic     flush_i,
   input  logic     valid_i,
   input  payload_t data_i,
   output logic     valid_o,
   output payload_t data_o
);

   logic     valid_q;
   payload_t data_q;

   // Flush wins over stall
   always_ff @(posedge clk) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else if (flush_i) begin
         valid_q <= 1'b0;
      end else if (!stall_i) begin
         valid_q <= valid_i;
      end
   end

   // Payload follows the input whenever the stage advances
   always_ff @(posedge clk) begin
      if (!stall_i) begin
         data_q <= data_i;
      end
   end

   assign valid_o = valid_q;
   assign data_o  = data_q;

   // Stage is empty one edge after reset or flush
   a_empty_after_clear : assert property (@(posedge clk) (rst_i || flush_i) |=> !valid_o);

endmodule

`default_nettype wire

/* design/insn_decode.sv */
// ########################################
// OpenRISC instruction decoder
// Purely combinational, fetch record in and
// decoded record out
// ########################################

`timescale 1ns/1ps
`default_nettype none

module insn_decode (
   input  logic                     clk,
   input  or1k_decode_pkg::fetch_t  fetch_i,
   output or1k_decode_pkg::decode_t dec_o
);

   logic [or1k_decode_pkg::insn_width-1:0]    insn;
   logic [or1k_decode_pkg::opcode_width-1:0]  opc;
   logic [or1k_decode_pkg::alu_opc_width-1:0] alu_opc;
   logic [or1k_decode_pkg::alu_opc_width-1:0] alu_sec;
   logic [4:0]                                sys_opc;
   logic [15:0]                               imm16;
   logic                                      sext_sel;
   logic                                      zext_sel;
   logic                                      high_sel;
   logic [1:0]                                lsu_len;
   logic                                      illegal;

   assign insn    = fetch_i.insn;
   assign opc     = insn[or1k_decode_pkg::opcode_msb:or1k_decode_pkg::opcode_lsb];
   assign alu_opc = insn[or1k_decode_pkg::alu_opc_msb:or1k_decode_pkg::alu_opc_lsb];
   assign alu_sec = insn[or1k_decode_pkg::alu_sec_msb:or1k_decode_pkg::alu_sec_lsb];
   assign sys_opc = insn[or1k_decode_pkg::sys_msb:or1k_decode_pkg::sys_lsb];

   assign dec_o.pc      = fetch_i.pc;
   assign dec_o.opc     = opc;
   assign dec_o.alu_opc = alu_opc;

   // Loads sit at 10_0000 up to 10_0110
   assign dec_o.op_load  = (opc[5:4] == 2'b10) && !opc[3] && (opc[2:0] != 3'b111);
   assign dec_o.op_store = (opc == or1k_decode_pkg::opc_sw) ||
                           (opc == or1k_decode_pkg::opc_sb) ||
                           (opc == or1k_decode_pkg::opc_sh);

   always_comb begin
      case (opc)
         or1k_decode_pkg::opc_sb,
         or1k_decode_pkg::opc_lbz,
         or1k_decode_pkg::opc_lbs: lsu_len = 2'b00;
         or1k_decode_pkg::opc_sh,
         or1k_decode_pkg::opc_lhz,
         or1k_decode_pkg::opc_lhs: lsu_len = 2'b01;
         default:                  lsu_len = 2'b10;
      endcase
   end

   assign dec_o.lsu_len  = lsu_len;
   assign dec_o.lsu_zext = opc[0];

   assign dec_o.op_mfspr   = opc == or1k_decode_pkg::opc_mfspr;
   assign dec_o.op_mtspr   = opc == or1k_decode_pkg::opc_mtspr;
   assign dec_o.op_rfe     = opc == or1k_decode_pkg::opc_rfe;
   assign dec_o.op_setflag = (opc == or1k_decode_pkg::opc_sf) ||
                             (opc == or1k_decode_pkg::opc_sfimm);

   // Immediate ALU ops, register ALU ops, SPR moves and movhi
   assign dec_o.op_alu = ((opc[5:4] == 2'b10) && (opc[3] || (opc[2:0] == 3'b111))) ||
                         (opc[5:3] == 3'b111) ||
                         dec_o.op_mtspr || dec_o.op_mfspr ||
                         (opc == or1k_decode_pkg::opc_movhi);

   // Opcodes below l.nop branch on an immediate offset
   assign dec_o.op_jbr    = opc < or1k_decode_pkg::opc_nop;
   assign dec_o.op_jr     = (opc == or1k_decode_pkg::opc_jr) ||
                            (opc == or1k_decode_pkg::opc_jalr);
   assign dec_o.op_jal    = (opc == or1k_decode_pkg::opc_jal) ||
                            (opc == or1k_decode_pkg::opc_jalr);
   assign dec_o.op_branch = dec_o.op_jbr || dec_o.op_jr || dec_o.op_jal;

   assign dec_o.rf_wb = dec_o.op_jal || (opc == or1k_decode_pkg::opc_movhi) ||
                        ((opc[5:4] == 2'b10) && (opc != or1k_decode_pkg::opc_sfimm)) ||
                        ((opc[5:4] == 2'b11) && !((opc == or1k_decode_pkg::opc_sf) ||
                                                  dec_o.op_mtspr || dec_o.op_store));

   assign dec_o.rfa = insn[or1k_decode_pkg::ra_msb:or1k_decode_pkg::ra_lsb];
   assign dec_o.rfb = insn[or1k_decode_pkg::rb_msb:or1k_decode_pkg::rb_lsb];
   assign dec_o.rfd = dec_o.op_jal ? or1k_decode_pkg::link_reg :
                      insn[or1k_decode_pkg::rd_msb:or1k_decode_pkg::rd_lsb];

   // Stores and mtspr split the immediate around the rb field
   assign imm16 = (dec_o.op_mtspr || dec_o.op_store) ? {insn[25:21], insn[10:0]} :
                  insn[or1k_decode_pkg::imm16_msb:or1k_decode_pkg::imm16_lsb];

   assign sext_sel = ((opc[5:4] == 2'b10) &&
                      (opc != or1k_decode_pkg::opc_ori) &&
                      (opc != or1k_decode_pkg::opc_andi)) ||
                     dec_o.op_store;
   assign zext_sel = (opc == or1k_decode_pkg::opc_ori) ||
                     (opc == or1k_decode_pkg::opc_andi) ||
                     dec_o.op_mtspr;
   assign high_sel = opc == or1k_decode_pkg::opc_movhi;

   assign dec_o.imm     = sext_sel ? {{16{imm16[15]}}, imm16} :
                          zext_sel ? {16'h0000, imm16} : {imm16, 16'h0000};
   assign dec_o.imm_sel = sext_sel || zext_sel || high_sel;

   // Compare code for setflag, shift type otherwise
   assign dec_o.alu_opc_sec = dec_o.op_setflag ?
                              insn[or1k_decode_pkg::comp_msb:or1k_decode_pkg::comp_lsb] :
                              alu_sec;

   // Compares run through the adder as a subtract
   assign dec_o.adder_sub   = ((opc == or1k_decode_pkg::opc_alu) &&
                               (alu_opc == or1k_decode_pkg::alu_sub)) ||
                              dec_o.op_setflag;
   assign dec_o.adder_carry = or1k_decode_pkg::feat_addc &&
                              (((opc == or1k_decode_pkg::opc_alu) &&
                                (alu_opc == or1k_decode_pkg::alu_addc)) ||
                               (opc == or1k_decode_pkg::opc_addic));

   assign dec_o.exc_syscall = (opc == or1k_decode_pkg::opc_systrapsync) &&
                              (sys_opc == or1k_decode_pkg::sys_syscall);
   assign dec_o.exc_trap    = (opc == or1k_decode_pkg::opc_systrapsync) &&
                              (sys_opc == or1k_decode_pkg::sys_trap);

   // Illegal instruction, custom opcodes land in default
   always_comb begin
      case (opc)
         or1k_decode_pkg::opc_j, or1k_decode_pkg::opc_jal,
         or1k_decode_pkg::opc_bnf, or1k_decode_pkg::opc_bf,
         or1k_decode_pkg::opc_nop, or1k_decode_pkg::opc_movhi,
         or1k_decode_pkg::opc_rfe, or1k_decode_pkg::opc_jr,
         or1k_decode_pkg::opc_jalr, or1k_decode_pkg::opc_lwz,
         or1k_decode_pkg::opc_lws, or1k_decode_pkg::opc_lbz,
         or1k_decode_pkg::opc_lbs, or1k_decode_pkg::opc_lhz,
         or1k_decode_pkg::opc_lhs, or1k_decode_pkg::opc_addi,
         or1k_decode_pkg::opc_andi, or1k_decode_pkg::opc_ori,
         or1k_decode_pkg::opc_xori, or1k_decode_pkg::opc_mfspr,
         or1k_decode_pkg::opc_sfimm, or1k_decode_pkg::opc_mtspr,
         or1k_decode_pkg::opc_sw, or1k_decode_pkg::opc_sb,
         or1k_decode_pkg::opc_sh, or1k_decode_pkg::opc_sf: illegal = 1'b0;
         or1k_decode_pkg::opc_addic: illegal = !or1k_decode_pkg::feat_addc;
         or1k_decode_pkg::opc_muli:  illegal = !or1k_decode_pkg::feat_mul;
         or1k_decode_pkg::opc_shrti: begin
            case (alu_sec)
               or1k_decode_pkg::shrt_sll,
               or1k_decode_pkg::shrt_srl: illegal = 1'b0;
               or1k_decode_pkg::shrt_sra: illegal = !or1k_decode_pkg::feat_sra;
               or1k_decode_pkg::shrt_ror: illegal = !or1k_decode_pkg::feat_ror;
               default:                   illegal = 1'b1;
            endcase
         end
         or1k_decode_pkg::opc_alu: begin
            case (alu_opc)
               or1k_decode_pkg::alu_add, or1k_decode_pkg::alu_sub,
               or1k_decode_pkg::alu_and, or1k_decode_pkg::alu_or,
               or1k_decode_pkg::alu_xor: illegal = 1'b0;
               or1k_decode_pkg::alu_addc: illegal = !or1k_decode_pkg::feat_addc;
               or1k_decode_pkg::alu_mul,
               or1k_decode_pkg::alu_mulu: illegal = !or1k_decode_pkg::feat_mul;
               or1k_decode_pkg::alu_div,
               or1k_decode_pkg::alu_divu: illegal = !or1k_decode_pkg::feat_div;
               or1k_decode_pkg::alu_ffl1: illegal = !or1k_decode_pkg::feat_ffl1;
               or1k_decode_pkg::alu_cmov: illegal = !or1k_decode_pkg::feat_cmov;
               or1k_decode_pkg::alu_ext:  illegal = !or1k_decode_pkg::feat_ext;
               or1k_decode_pkg::alu_shrt: begin
                  case (alu_sec)
                     or1k_decode_pkg::shrt_sll,
                     or1k_decode_pkg::shrt_srl: illegal = 1'b0;
                     or1k_decode_pkg::shrt_sra: illegal = !or1k_decode_pkg::feat_sra;
                     or1k_decode_pkg::shrt_ror: illegal = !or1k_decode_pkg::feat_ror;
                     default:                   illegal = 1'b1;
                  endcase
               end
               default: illegal = 1'b1;
            endcase
         end
         or1k_decode_pkg::opc_systrapsync: begin
            illegal = !((dec_o.exc_syscall && or1k_decode_pkg::feat_syscall) ||
                        (dec_o.exc_trap && or1k_decode_pkg::feat_trap));
         end
         default: illegal = 1'b1;
      endcase
   end

   assign dec_o.exc_illegal = illegal;

   // Checked in the clock domain of the stage registers around the decoder
   a_lsu_onehot : assert property (@(posedge clk) !(dec_o.op_load && dec_o.op_store));
   a_sys_onehot : assert property (@(posedge clk) !(dec_o.exc_syscall && dec_o.exc_trap));

endmodule

`default_nettype wire

/* design/decode_stage_top.sv */
// ########################################
// Decode stage top level
// Fetch register, decoder and execute register,
// decoded record flattened onto ports
// ########################################

`timescale 1ns/1ps
`default_nettype none

module decode_stage_top (
   input  logic        clk,
   input  logic        rst_i,
   input  logic        insn_valid_i,
   input  logic [31:0] pc_i,
   input  logic [31:0] insn_i,
   input  logic        stall_i,
   input  logic        flush_i,
   output logic        dec_valid_o,
   output logic [31:0] dec_pc_o,
   output logic [5:0]  dec_opc_o,
   output logic [3:0]  dec_alu_opc_o,
   output logic [3:0]  dec_alu_opc_sec_o,
   output logic [31:0] dec_imm_o,
   output logic        dec_imm_sel_o,
   output logic [4:0]  dec_rfd_o,
   output logic [4:0]  dec_rfa_o,
   output logic [4:0]  dec_rfb_o,
   output logic        dec_rf_wb_o,
   output logic        dec_op_alu_o,
   output logic        dec_op_load_o,
   output logic        dec_op_store_o,
   output logic [1:0]  dec_lsu_len_o,
   output logic        dec_lsu_zext_o,
   output logic        dec_op_mfspr_o,
   output logic        dec_op_mtspr_o,
   output logic        dec_op_setflag_o,
   output logic        dec_op_rfe_o,
   output logic        dec_op_jbr_o,
   output logic        dec_op_jr_o,
   output logic        dec_op_jal_o,
   output logic        dec_op_branch_o,
   output logic        dec_adder_sub_o,
   output logic        dec_adder_carry_o,
   output logic        dec_exc_illegal_o,
   output logic        dec_exc_syscall_o,
   output logic        dec_exc_trap_o
);

   or1k_decode_pkg::fetch_t  fetch_in;
   or1k_decode_pkg::fetch_t  fetch_q;
   or1k_decode_pkg::decode_t dec_d;
   or1k_decode_pkg::decode_t dec_q;
   logic                     fetch_valid;

   assign fetch_in.pc   = pc_i;
   assign fetch_in.insn = insn_i;

   pipe_stage_reg #(
      .payload_t (or1k_decode_pkg::fetch_t)
   ) u_fetch_reg (
      .clk     (clk),
      .rst_i   (rst_i),
      .stall_i (stall_i),
      .flush_i (flush_i),
      .valid_i (insn_valid_i),
      .data_i  (fetch_in),
      .valid_o (fetch_valid),
      .data_o  (fetch_q)
   );

   insn_decode u_insn_decode (
      .clk     (clk),
      .fetch_i (fetch_q),
      .dec_o   (dec_d)
   );

   pipe_stage_reg #(
      .payload_t (or1k_decode_pkg::decode_t)
   ) u_exec_reg (
      .clk     (clk),
      .rst_i   (rst_i),
      .stall_i (stall_i),
      .flush_i (flush_i),
      .valid_i (fetch_valid),
      .data_i  (dec_d),
      .valid_o (dec_valid_o),
      .data_o  (dec_q)
   );

   // Record out to the execute stage
   assign dec_pc_o          = dec_q.pc;
   assign dec_opc_o         = dec_q.opc;
   assign dec_alu_opc_o     = dec_q.alu_opc;
   assign dec_alu_opc_sec_o = dec_q.alu_opc_sec;
   assign dec_imm_o         = dec_q.imm;
   assign dec_imm_sel_o     = dec_q.imm_sel;
   assign dec_rfd_o         = dec_q.rfd;
   assign dec_rfa_o         = dec_q.rfa;
   assign dec_rfb_o         = dec_q.rfb;
   assign dec_rf_wb_o       = dec_q.rf_wb;
   assign dec_op_alu_o      = dec_q.op_alu;
   assign dec_op_load_o     = dec_q.op_load;
   assign dec_op_store_o    = dec_q.op_store;
   assign dec_lsu_len_o     = dec_q.lsu_len;
   assign dec_lsu_zext_o    = dec_q.lsu_zext;
   assign dec_op_mfspr_o    = dec_q.op_mfspr;
   assign dec_op_mtspr_o    = dec_q.op_mtspr;
   assign dec_op_setflag_o  = dec_q.op_setflag;
   assign dec_op_rfe_o      = dec_q.op_rfe;
   assign dec_op_jbr_o      = dec_q.op_jbr;
   assign dec_op_jr_o       = dec_q.op_jr;
   assign dec_op_jal_o      = dec_q.op_jal;
   assign dec_op_branch_o   = dec_q.op_branch;
   assign dec_adder_sub_o   = dec_q.adder_sub;
   assign dec_adder_carry_o = dec_q.adder_carry;
   assign dec_exc_illegal_o = dec_q.exc_illegal;
   assign dec_exc_syscall_o = dec_q.exc_syscall;
   assign dec_exc_trap_o    = dec_q.exc_trap;

endmodule

`default_nettype wire

/* dv/decode_stage_tb.sv */
// ########################################
// Decode stage testbench
// Table-driven decode checks, random stalls,
// flush and reset behavior of the two stages
// ########################################

`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;

   // Class flag order {alu, load, store, setflag, mtspr, mfspr, rfe, jbr, jr, jal, branch, sub}
   typedef struct packed {
      logic [31:0] insn;
      logic [31:0] imm;
      logic        imm_sel;
      logic [4:0]  rfd;
      logic        wb;
      logic [11:0] cls;
      logic [1:0]  len;
      logic        zext;
      logic [2:0]  exc;
   } vec_t;

   logic        clk;
   logic        rst_i;
   logic        insn_valid_i;
   logic [31:0] pc_i;
   logic [31:0] insn_i;
   logic        stall_i;
   logic        flush_i;
   logic        dec_valid_o;
   logic [31:0] dec_pc_o;
   logic [5:0]  dec_opc_o;
   logic [3:0]  dec_alu_opc_o;
   logic [3:0]  dec_alu_opc_sec_o;
   logic [31:0] dec_imm_o;
   logic        dec_imm_sel_o;
   logic [4:0]  dec_rfd_o;
   logic [4:0]  dec_rfa_o;
   logic [4:0]  dec_rfb_o;
   logic        dec_rf_wb_o;
   logic        dec_op_alu_o;
   logic        dec_op_load_o;
   logic        dec_op_store_o;
   logic [1:0]  dec_lsu_len_o;
   logic        dec_lsu_zext_o;
   logic        dec_op_mfspr_o;
   logic        dec_op_mtspr_o;
   logic        dec_op_setflag_o;
   logic        dec_op_rfe_o;
   logic        dec_op_jbr_o;
   logic        dec_op_jr_o;
   logic        dec_op_jal_o;
   logic        dec_op_branch_o;
   logic        dec_adder_sub_o;
   logic        dec_adder_carry_o;
   logic        dec_exc_illegal_o;
   logic        dec_exc_syscall_o;
   logic        dec_exc_trap_o;

   vec_t        vecs[$];
   int          exp_idx[$];
   logic [31:0] exp_pc[$];
   int          cur_idx;
   int          errors;
   int          checks;
   logic [31:0] seed;

   decode_stage_top decode_stage_top_i (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic add_vec(input logic [31:0] insn, input logic [31:0] imm, input logic sel,
                          input logic [4:0] rfd, input logic wb, input logic [11:0] cls,
                          input logic [1:0] len, input logic zext, input logic [2:0] exc);
      vecs.push_back('{insn, imm, sel, rfd, wb, cls, len, zext, exc});
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act) else begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic compare_out(input int idx, input logic [31:0] pc);
      vec_t v;
      v = vecs[idx];
      check_val("dec_pc_o", pc, dec_pc_o);
      // Opcode and register fields straight from the instruction word
      check_val("dec_opc_o", v.insn[31:26], dec_opc_o);
      check_val("dec_alu_opc_o", v.insn[3:0], dec_alu_opc_o);
      check_val("dec_alu_opc_sec_o", v.cls[8] ? v.insn[24:21] : v.insn[9:6],
                dec_alu_opc_sec_o);
      check_val("dec_rfa_o", v.insn[20:16], dec_rfa_o);
      check_val("dec_rfb_o", v.insn[15:11], dec_rfb_o);
      check_val("dec_imm_sel_o", v.imm_sel, dec_imm_sel_o);
      if (v.imm_sel) check_val("dec_imm_o", v.imm, dec_imm_o);
      check_val("dec_rf_wb_o", v.wb, dec_rf_wb_o);
      if (v.wb) check_val("dec_rfd_o", v.rfd, dec_rfd_o);
      check_val("dec_op_alu_o", v.cls[11], dec_op_alu_o);
      check_val("dec_op_load_o", v.cls[10], dec_op_load_o);
      check_val("dec_op_store_o", v.cls[9], dec_op_store_o);
      check_val("dec_op_setflag_o", v.cls[8], dec_op_setflag_o);
      check_val("dec_op_mtspr_o", v.cls[7], dec_op_mtspr_o);
      check_val("dec_op_mfspr_o", v.cls[6], dec_op_mfspr_o);
      check_val("dec_op_rfe_o", v.cls[5], dec_op_rfe_o);
      check_val("dec_op_jbr_o", v.cls[4], dec_op_jbr_o);
      check_val("dec_op_jr_o", v.cls[3], dec_op_jr_o);
      check_val("dec_op_jal_o", v.cls[2], dec_op_jal_o);
      check_val("dec_op_branch_o", v.cls[1], dec_op_branch_o);
      check_val("dec_adder_sub_o", v.cls[0], dec_adder_sub_o);
      // Carry-in never used, addc is not built in
      check_val("dec_adder_carry_o", 1'b0, dec_adder_carry_o);
      // Length only matters for memory ops, zext only for loads
      if (v.cls[10] || v.cls[9]) check_val("dec_lsu_len_o", v.len, dec_lsu_len_o);
      if (v.cls[10]) check_val("dec_lsu_zext_o", v.zext, dec_lsu_zext_o);
      check_val("dec_exc_illegal_o", v.exc[2], dec_exc_illegal_o);
      check_val("dec_exc_syscall_o", v.exc[1], dec_exc_syscall_o);
      check_val("dec_exc_trap_o", v.exc[0], dec_exc_trap_o);
   endtask

   // Outputs are consumed and inputs accepted at the coming rising edge
   always @(negedge clk) begin
      if (!rst_i && dec_valid_o && !stall_i) begin
         assert (exp_idx.size() != 0) else begin
            $display("Output valid at %0t with no instruction in flight", $time);
            errors++;
         end
         if (exp_idx.size() != 0) begin
            compare_out(exp_idx.pop_front(), exp_pc.pop_front());
         end
      end
      if (flush_i) begin
         exp_idx.delete();
         exp_pc.delete();
      end else if (!rst_i && insn_valid_i && !stall_i) begin
         exp_idx.push_back(cur_idx);
         exp_pc.push_back(pc_i);
      end
   end

   task automatic run_stream(input bit random_mode);
      int idx;
      bit moved;
      idx = 0;
      moved = 1'b1;
      while (idx < vecs.size()) begin
         @(posedge clk);
         #1;
         if (moved) begin
            seed = lcg_next(seed);
            insn_valid_i = random_mode ? (seed[20:18] != 3'd0) : 1'b1;
            cur_idx = idx;
            insn_i = vecs[idx].insn;
            pc_i = random_mode ? {seed[31:2], 2'b00} : 32'h1000 + idx * 4;
         end
         seed = lcg_next(seed);
         stall_i = random_mode && (seed[17:16] == 2'd0);
         moved = !stall_i;
         if (moved && insn_valid_i) idx++;
      end
      @(posedge clk);
      #1;
      insn_valid_i = 1'b0;
      stall_i = 1'b0;
      while (exp_idx.size() != 0) @(posedge clk);
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %-14s %s (%0d errors)", name,
               (errors == errs_before) ? "ok" : "failed", errors - errs_before);
   endtask

   task automatic build_table();
      // ALU register ops
      add_vec(32'hE0642800, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE0642802, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0001, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE0642803, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE0642804, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE0642805, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE0642808, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE0642888, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE0642806, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'hE4042800, 32'h0, 1'b0, 5'd0, 1'b0, 12'b1001_0000_0001, 2'd0, 1'b0, 3'b000);
      // Immediates
      add_vec(32'h9C64FFFE, 32'hFFFFFFFE, 1'b1, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0,
              3'b000);
      add_vec(32'hA8648001, 32'h00008001, 1'b1, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0,
              3'b000);
      add_vec(32'hA464F00F, 32'h0000F00F, 1'b1, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0,
              3'b000);
      add_vec(32'h18601234, 32'h12340000, 1'b1, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0,
              3'b000);
      add_vec(32'hC2242801, 32'h00008801, 1'b1, 5'd0, 1'b0, 12'b1000_1000_0000, 2'd0, 1'b0,
              3'b000);
      add_vec(32'hB4640010, 32'h00000010, 1'b1, 5'd3, 1'b1, 12'b1000_0100_0000, 2'd0, 1'b0,
              3'b000);
      // Loads and stores
      add_vec(32'hD4442A34, 32'h00001234, 1'b1, 5'd0, 1'b0, 12'b0010_0000_0000, 2'd2, 1'b0,
              3'b000);
      add_vec(32'hDA042804, 32'hFFFF8004, 1'b1, 5'd0, 1'b0, 12'b0010_0000_0000, 2'd0, 1'b0,
              3'b000);
      add_vec(32'hDC042810, 32'h00000010, 1'b1, 5'd0, 1'b0, 12'b0010_0000_0000, 2'd1, 1'b0,
              3'b000);
      add_vec(32'h84640004, 32'h00000004, 1'b1, 5'd3, 1'b1, 12'b0100_0000_0000, 2'd2, 1'b1,
              3'b000);
      add_vec(32'h9064FFFF, 32'hFFFFFFFF, 1'b1, 5'd3, 1'b1, 12'b0100_0000_0000, 2'd0, 1'b0,
              3'b000);
      add_vec(32'h94640002, 32'h00000002, 1'b1, 5'd3, 1'b1, 12'b0100_0000_0000, 2'd1, 1'b1,
              3'b000);
      add_vec(32'h8C640001, 32'h00000001, 1'b1, 5'd3, 1'b1, 12'b0100_0000_0000, 2'd0, 1'b1,
              3'b000);
      // Jumps and branches, link register is r9
      add_vec(32'h00000010, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0001_0010, 2'd0, 1'b0, 3'b000);
      add_vec(32'h10000008, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0001_0010, 2'd0, 1'b0, 3'b000);
      add_vec(32'h0C000008, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0001_0010, 2'd0, 1'b0, 3'b000);
      add_vec(32'h04000004, 32'h0, 1'b0, 5'd9, 1'b1, 12'b0000_0001_0110, 2'd0, 1'b0, 3'b000);
      add_vec(32'h44002800, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0000_1010, 2'd0, 1'b0, 3'b000);
      add_vec(32'h48002800, 32'h0, 1'b0, 5'd9, 1'b1, 12'b0000_0000_1110, 2'd0, 1'b0, 3'b000);
      // Exceptions, rfe and nop
      add_vec(32'h20000001, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0000_0000, 2'd0, 1'b0, 3'b010);
      add_vec(32'h21000000, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0000_0000, 2'd0, 1'b0, 3'b001);
      add_vec(32'hE06428C8, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b100);
      add_vec(32'hE0642809, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b100);
      add_vec(32'hE0642801, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b100);
      add_vec(32'hE0642807, 32'h0, 1'b0, 5'd3, 1'b1, 12'b1000_0000_0000, 2'd0, 1'b0, 3'b100);
      add_vec(32'h70000000, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0000_0000, 2'd0, 1'b0, 3'b100);
      add_vec(32'h24000000, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0010_0000, 2'd0, 1'b0, 3'b000);
      add_vec(32'h15000000, 32'h0, 1'b0, 5'd0, 1'b0, 12'b0000_0000_0000, 2'd0, 1'b0, 3'b000);
   endtask

   // Watchdog scaled from the table length
   initial begin
      #1;
      #((vecs.size() * 3 + 40) * 10 * 4);
      $display("Timeout, the run did not finish in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      int errs;
      clk = 1'b0;
      rst_i = 1'b1;
      insn_valid_i = 1'b0;
      pc_i = 32'h0;
      insn_i = 32'h0;
      stall_i = 1'b0;
      flush_i = 1'b0;
      cur_idx = 0;
      errors = 0;
      checks = 0;
      seed = 32'hf056;
      build_table();

      errs = errors;
      repeat (8) @(posedge clk);
      #1;
      rst_i = 1'b0;
      check_val("dec_valid_o", 1'b0, dec_valid_o);
      report_test("reset", errs);

      errs = errors;
      run_stream(1'b0);
      report_test("decode_table", errs);

      errs = errors;
      run_stream(1'b1);
      report_test("random_stall", errs);

      // Two instructions in flight, then flush
      errs = errors;
      @(posedge clk);
      #1;
      cur_idx = 0;
      insn_i = vecs[0].insn;
      pc_i = 32'h2000;
      insn_valid_i = 1'b1;
      @(posedge clk);
      #1;
      pc_i = 32'h2004;
      @(posedge clk);
      #1;
      insn_valid_i = 1'b0;
      flush_i = 1'b1;
      @(posedge clk);
      #1;
      flush_i = 1'b0;
      check_val("dec_valid_o", 1'b0, dec_valid_o);
      @(posedge clk);
      #1;
      check_val("dec_valid_o", 1'b0, dec_valid_o);
      report_test("flush", errs);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* or1k_decode.f */
design/or1k_decode_pkg.sv
design/pipe_stage_reg.sv
design/insn_decode.sv
design/decode_stage_top.sv
dv/decode_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FLIST     ?= or1k_decode.f
BUILD_DIR ?= build

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
